//--- src/xform_defs.svh
`ifndef XFORM_DEFS_SVH
`define XFORM_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////////////////////////
`define XF_INSN_W 32
`define XF_OPCD_W 6
`define XF_XO_W 10
`define XF_REG_W 5

// primary opcodes
`define XF_OPCD_FIXED 6'd31
`define XF_OPCD_FLOAT 6'd63

//////////////////////////////////////////////////////////////////////
// primary 31, fixed point
//////////////////////////////////////////////////////////////////////
// indexed loads and stores, plain form
`define XF_XO_LBZX 10'd87
`define XF_XO_LHZX 10'd279
`define XF_XO_LHAX 10'd343
`define XF_XO_LWZX 10'd23
`define XF_XO_LWAX 10'd341
`define XF_XO_LDX 10'd21
`define XF_XO_STBX 10'd215
`define XF_XO_STHX 10'd407
`define XF_XO_STWX 10'd151
`define XF_XO_STDX 10'd149
// with update
`define XF_XO_LBZUX 10'd119
`define XF_XO_LHZUX 10'd311
`define XF_XO_LHAUX 10'd375
`define XF_XO_LWZUX 10'd55
`define XF_XO_LWAUX 10'd373
`define XF_XO_LDUX 10'd53
`define XF_XO_STBUX 10'd247
`define XF_XO_STHUX 10'd439
`define XF_XO_STWUX 10'd183
`define XF_XO_STDUX 10'd181
// compares
`define XF_XO_CMP 10'd0
`define XF_XO_CMPL 10'd32
// two-operand logical
`define XF_XO_AND 10'd28
`define XF_XO_OR 10'd444
`define XF_XO_XOR 10'd316
`define XF_XO_NAND 10'd476
`define XF_XO_NOR 10'd124
`define XF_XO_EQV 10'd284
`define XF_XO_ANDC 10'd60
`define XF_XO_ORC 10'd412
// shifts
`define XF_XO_SLW 10'd24
`define XF_XO_SRW 10'd536
`define XF_XO_SRAW 10'd792
`define XF_XO_SLD 10'd27
`define XF_XO_SRD 10'd539
`define XF_XO_SRAD 10'd794
// one source, RB unused
`define XF_XO_EXTSB 10'd954
`define XF_XO_EXTSH 10'd922
`define XF_XO_EXTSW 10'd986
`define XF_XO_CNTLZW 10'd26
`define XF_XO_CNTLZD 10'd58
`define XF_XO_POPCNTB 10'd122
`define XF_XO_PRTYW 10'd154

//////////////////////////////////////////////////////////////////////
// primary 63, floating point
//////////////////////////////////////////////////////////////////////
`define XF_XO_FMR 10'd72
`define XF_XO_FNEG 10'd40
`define XF_XO_FABS 10'd264
`define XF_XO_FNABS 10'd136
`define XF_XO_FCPSGN 10'd8
`define XF_XO_FCMPU 10'd0
`define XF_XO_FCMPO 10'd32
`define XF_XO_FRSP 10'd12
`define XF_XO_FCTIW 10'd14
`define XF_XO_FCTIWZ 10'd15
`define XF_XO_FCTID 10'd814
`define XF_XO_FCTIDZ 10'd815

`endif

//--- src/xform_pkg.sv
`include "xform_defs.svh"

package xform_pkg;

	// bit 0 is the MSB, as in the ISA book
	typedef struct packed {
		logic [0:`XF_OPCD_W-1] opcd;
		logic [0:`XF_REG_W-1] rt;
		logic [0:`XF_REG_W-1] ra;
		logic [0:`XF_REG_W-1] rb;
		logic [0:`XF_XO_W-1] xo;
		logic rc;
	} xform_regs_t;

	// compare layout, RT splits into BF / reserved / L
	typedef struct packed {
		logic [0:`XF_OPCD_W-1] opcd;
		logic [0:2] bf;
		logic rsvd;
		logic l;
		logic [0:`XF_REG_W-1] ra;
		logic [0:`XF_REG_W-1] rb;
		logic [0:`XF_XO_W-1] xo;
		logic rc;
	} xform_cmp_t;

	typedef union packed {
		xform_regs_t regs;
		xform_cmp_t cmp;
	} xform_word_u;

	// one decoder's verdict
	typedef struct packed {
		logic hit;
		logic [0:`XF_REG_W-1] reg1;
		logic [0:`XF_REG_W-1] reg2;
		logic [0:`XF_REG_W-1] reg3;
		logic ra_zero;
	} xo_result_t;

endpackage

//--- src/fixed_point_xo_decoder.sv
`include "xform_defs.svh"

module fixed_point_xo_decoder import xform_pkg::*; (
	input xform_word_u insn_i,
	output xo_result_t result_o
);

	logic is_fixed;
	logic ls_plain;
	logic ls_update;
	logic cmp_op;
	logic two_src;
	logic one_src;
	logic known;

	assign is_fixed = (insn_i.regs.opcd == `XF_OPCD_FIXED);

	//////////////////////////////////////////////////////////////////////
	// sort the XO into classes
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		ls_plain = 1'b0;
		ls_update = 1'b0;
		cmp_op = 1'b0;
		two_src = 1'b0;
		one_src = 1'b0;
		case (insn_i.regs.xo)
			`XF_XO_LBZX, `XF_XO_LHZX, `XF_XO_LHAX, `XF_XO_LWZX, `XF_XO_LWAX,
			`XF_XO_LDX, `XF_XO_STBX, `XF_XO_STHX, `XF_XO_STWX, `XF_XO_STDX: begin
				ls_plain = 1'b1;
			end
			`XF_XO_LBZUX, `XF_XO_LHZUX, `XF_XO_LHAUX, `XF_XO_LWZUX, `XF_XO_LWAUX,
			`XF_XO_LDUX, `XF_XO_STBUX, `XF_XO_STHUX, `XF_XO_STWUX, `XF_XO_STDUX: begin
				ls_update = 1'b1;
			end
			`XF_XO_CMP, `XF_XO_CMPL: begin
				cmp_op = 1'b1;
			end
			`XF_XO_AND, `XF_XO_OR, `XF_XO_XOR, `XF_XO_NAND,
			`XF_XO_NOR, `XF_XO_EQV, `XF_XO_ANDC, `XF_XO_ORC,
			`XF_XO_SLW, `XF_XO_SRW, `XF_XO_SRAW,
			`XF_XO_SLD, `XF_XO_SRD, `XF_XO_SRAD: begin
				two_src = 1'b1;
			end
			`XF_XO_EXTSB, `XF_XO_EXTSH, `XF_XO_EXTSW, `XF_XO_CNTLZW,
			`XF_XO_CNTLZD, `XF_XO_POPCNTB, `XF_XO_PRTYW: begin
				one_src = 1'b1;
			end
			default: begin
				// not a kept primary-31 code
			end
		endcase
	end

	assign known = ls_plain | ls_update | cmp_op | two_src | one_src;

	//////////////////////////////////////////////////////////////////////
	// register fields
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		result_o = '0;
		if (is_fixed && known) begin
			result_o.hit = 1'b1;
			// compares carry a CR field number in place of RT
			if (cmp_op) begin
				result_o.reg1 = {2'b00, insn_i.cmp.bf};
			end else begin
				result_o.reg1 = insn_i.regs.rt;
			end
			result_o.reg2 = insn_i.regs.ra;
			if (one_src) begin
				result_o.reg3 = '0;
			end else begin
				result_o.reg3 = insn_i.regs.rb;
			end
			// RA=0 means literal zero, except for update forms
			result_o.ra_zero = ls_plain;
		end
	end

endmodule

//--- src/float_xo_decoder.sv
`include "xform_defs.svh"

module float_xo_decoder import xform_pkg::*; (
	input xform_word_u insn_i,
	output xo_result_t result_o
);

	logic is_float;
	logic fcmp_op;
	logic fpass_op;

	assign is_float = (insn_i.regs.opcd == `XF_OPCD_FLOAT);

	always_comb begin
		fcmp_op = 1'b0;
		fpass_op = 1'b0;
		case (insn_i.regs.xo)
			`XF_XO_FCMPU, `XF_XO_FCMPO: begin
				fcmp_op = 1'b1;
			end
			// moves and sign ops
			`XF_XO_FMR, `XF_XO_FNEG, `XF_XO_FABS, `XF_XO_FNABS, `XF_XO_FCPSGN: begin
				fpass_op = 1'b1;
			end
			// round and convert to integer
			`XF_XO_FRSP, `XF_XO_FCTIW, `XF_XO_FCTIWZ,
			`XF_XO_FCTID, `XF_XO_FCTIDZ: begin
				fpass_op = 1'b1;
			end
			default: begin
				fpass_op = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// FRT / FRA / FRB, or BF for compares
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		result_o = '0;
		if (is_float && (fcmp_op || fpass_op)) begin
			result_o.hit = 1'b1;
			if (fcmp_op) begin
				result_o.reg1 = {2'b00, insn_i.cmp.bf};
			end else begin
				result_o.reg1 = insn_i.regs.rt;
			end
			result_o.reg2 = insn_i.regs.ra;
			result_o.reg3 = insn_i.regs.rb;
			// no FP base register, ra_zero stays low
			result_o.ra_zero = 1'b0;
		end
	end

endmodule

//--- src/xform_result_merge.sv
`include "xform_defs.svh"

module xform_result_merge import xform_pkg::*; (
	input logic clock_i,
	input logic reset_i,
	input logic in_valid_i,
	input logic [0:`XF_INSN_W-1] in_insn_i,
	output logic in_ready_o,
	input xo_result_t fixed_i,
	input xo_result_t float_i,
	input logic out_ready_i,
	output logic out_valid_o,
	output logic [0:`XF_OPCD_W-1] opcode_o,
	output logic [0:`XF_XO_W-1] xo_o,
	output logic [0:`XF_REG_W-1] reg1_o,
	output logic [0:`XF_REG_W-1] reg2_o,
	output logic [0:`XF_REG_W-1] reg3_o,
	output logic ra_zero_o,
	output logic rc_o,
	output logic illegal_o
);

	logic accept;
	logic sel_illegal;
	xo_result_t sel;

	// free slot, or the held result leaves this cycle
	assign in_ready_o = ~out_valid_o | out_ready_i;
	assign accept = in_valid_i & in_ready_o;

	always_comb begin
		if (fixed_i.hit) begin
			sel = fixed_i;
		end else if (float_i.hit) begin
			sel = float_i;
		end else begin
			sel = '0;
		end
	end

	assign sel_illegal = ~(fixed_i.hit | float_i.hit);

	//////////////////////////////////////////////////////////////////////
	// output stage
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (accept) begin
			opcode_o <= in_insn_i[0:`XF_OPCD_W-1];
			xo_o <= in_insn_i[`XF_INSN_W-`XF_XO_W-1:`XF_INSN_W-2];
			rc_o <= in_insn_i[`XF_INSN_W-1];
			reg1_o <= sel.reg1;
			reg2_o <= sel.reg2;
			reg3_o <= sel.reg3;
			ra_zero_o <= sel.ra_zero;
			illegal_o <= sel_illegal;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// assertions
	//////////////////////////////////////////////////////////////////////
	// decoders key on different primary opcodes
	hits_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
		!(fixed_i.hit && float_i.hit));

	hold_under_stall: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable({opcode_o, xo_o,
		reg1_o, reg2_o, reg3_o, ra_zero_o, rc_o, illegal_o}));

	empty_after_reset: assert property (@(posedge clock_i)
		reset_i |=> !out_valid_o);

endmodule

//--- src/xform_decoder_top.sv
`include "xform_defs.svh"

module xform_decoder_top import xform_pkg::*; (
	input logic clock_i,
	input logic reset_i,
	// instruction in
	input logic in_valid_i,
	input logic [0:`XF_INSN_W-1] in_insn_i,
	output logic in_ready_o,
	// decoded fields out
	output logic out_valid_o,
	input logic out_ready_i,
	output logic [0:`XF_OPCD_W-1] opcode_o,
	output logic [0:`XF_XO_W-1] xo_o,
	output logic [0:`XF_REG_W-1] reg1_o,
	output logic [0:`XF_REG_W-1] reg2_o,
	output logic [0:`XF_REG_W-1] reg3_o,
	output logic ra_zero_o,
	output logic rc_o,
	output logic illegal_o
);

	xo_result_t fixed_res;
	xo_result_t float_res;

	//////////////////////////////////////////////////////////////////////
	// decoders, side by side on the raw word
	//////////////////////////////////////////////////////////////////////
	fixed_point_xo_decoder u_fixed (
		.insn_i (in_insn_i),
		.result_o (fixed_res)
	);

	float_xo_decoder u_float (
		.insn_i (in_insn_i),
		.result_o (float_res)
	);

	//////////////////////////////////////////////////////////////////////
	// select and register
	//////////////////////////////////////////////////////////////////////
	xform_result_merge u_merge (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.in_valid_i (in_valid_i),
		.in_insn_i (in_insn_i),
		.in_ready_o (in_ready_o),
		.fixed_i (fixed_res),
		.float_i (float_res),
		.out_ready_i (out_ready_i),
		.out_valid_o (out_valid_o),
		.opcode_o (opcode_o),
		.xo_o (xo_o),
		.reg1_o (reg1_o),
		.reg2_o (reg2_o),
		.reg3_o (reg3_o),
		.ra_zero_o (ra_zero_o),
		.rc_o (rc_o),
		.illegal_o (illegal_o)
	);

endmodule

//--- testbench/xform_decoder_checks.sv
`include "xform_defs.svh"

module xform_decoder_checks (
	input logic clock_i,
	input logic reset_i,
	input logic in_valid_i,
	input logic [31:0] in_insn_i,
	input logic in_ready_o,
	input logic out_valid_o,
	input logic out_ready_i,
	input logic [5:0] opcode_o,
	input logic [9:0] xo_o,
	input logic [4:0] reg1_o,
	input logic [4:0] reg2_o,
	input logic [4:0] reg3_o,
	input logic ra_zero_o,
	input logic rc_o,
	input logic illegal_o,
	output int field_errors_o,
	output int protocol_errors_o,
	output int accepted_o,
	output int received_o,
	output int pending_o
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic illegal;
		logic [4:0] r1;
		logic [4:0] r2;
		logic [4:0] r3;
		logic raz;
	} expect_t;

	logic [31:0] pending[$];
	logic [31:0] head_word;
	logic head_present;
	expect_t exp_res;
	int field_errors;
	int protocol_errors;
	int accepted;
	int received;

	initial begin
		field_errors = 0;
		protocol_errors = 0;
		accepted = 0;
		received = 0;
		head_word = '0;
		head_present = 1'b0;
	end

	// expected decode straight from the instruction-set rules
	function automatic expect_t predict(input logic [31:0] w);
		expect_t e;
		logic [9:0] xo;
		logic plain;
		logic update;
		logic cmp;
		logic one;
		logic two;
		xo = w[10:1];
		e = '0;
		plain = xo inside {`XF_XO_LBZX, `XF_XO_LHZX, `XF_XO_LHAX, `XF_XO_LWZX, `XF_XO_LWAX,
			`XF_XO_LDX, `XF_XO_STBX, `XF_XO_STHX, `XF_XO_STWX, `XF_XO_STDX};
		update = xo inside {`XF_XO_LBZUX, `XF_XO_LHZUX, `XF_XO_LHAUX, `XF_XO_LWZUX,
			`XF_XO_LWAUX, `XF_XO_LDUX, `XF_XO_STBUX, `XF_XO_STHUX, `XF_XO_STWUX, `XF_XO_STDUX};
		cmp = xo inside {`XF_XO_CMP, `XF_XO_CMPL};
		one = xo inside {`XF_XO_EXTSB, `XF_XO_EXTSH, `XF_XO_EXTSW, `XF_XO_CNTLZW,
			`XF_XO_CNTLZD, `XF_XO_POPCNTB, `XF_XO_PRTYW};
		two = xo inside {`XF_XO_AND, `XF_XO_OR, `XF_XO_XOR, `XF_XO_NAND, `XF_XO_NOR,
			`XF_XO_EQV, `XF_XO_ANDC, `XF_XO_ORC, `XF_XO_SLW, `XF_XO_SRW, `XF_XO_SRAW,
			`XF_XO_SLD, `XF_XO_SRD, `XF_XO_SRAD};
		if (w[31:26] == `XF_OPCD_FLOAT) begin
			cmp = xo inside {`XF_XO_FCMPU, `XF_XO_FCMPO};
			two = xo inside {`XF_XO_FMR, `XF_XO_FNEG, `XF_XO_FABS, `XF_XO_FNABS,
				`XF_XO_FCPSGN, `XF_XO_FRSP, `XF_XO_FCTIW, `XF_XO_FCTIWZ, `XF_XO_FCTID,
				`XF_XO_FCTIDZ};
			plain = 1'b0;
			update = 1'b0;
			one = 1'b0;
		end else if (w[31:26] != `XF_OPCD_FIXED) begin
			cmp = 1'b0;
			two = 1'b0;
			plain = 1'b0;
			update = 1'b0;
			one = 1'b0;
		end
		if (!(plain || update || cmp || one || two)) begin
			e.illegal = 1'b1;
			return e;
		end
		e.r1 = cmp ? {2'b00, w[25:23]} : w[25:21];
		e.r2 = w[20:16];
		e.r3 = one ? 5'd0 : w[15:11];
		e.raz = plain;
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// scoreboard queue
	//////////////////////////////////////////////////////////////////////
	always @(posedge clock_i) begin
		if (reset_i) begin
			pending.delete();
		end else begin
			if (out_valid_o && out_ready_i) begin
				received++;
				if (pending.size() > 0) begin
					void'(pending.pop_front());
				end
			end
			if (in_valid_i && in_ready_o) begin
				accepted++;
				pending.push_back(in_insn_i);
			end
		end
		head_present <= (pending.size() > 0);
		head_word <= (pending.size() > 0) ? pending[0] : '0;
	end

	assign exp_res = predict(head_word);
	assign field_errors_o = field_errors;
	assign protocol_errors_o = protocol_errors;
	assign accepted_o = accepted;
	assign received_o = received;
	assign pending_o = pending.size();

	//////////////////////////////////////////////////////////////////////
	// field checks against the head of the queue
	//////////////////////////////////////////////////////////////////////
	chk_opcode: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> opcode_o == head_word[31:26])
		else begin
			field_errors++;
			$display("[FAIL] opcode: expected %0d, actual %0d",
				$sampled(head_word[31:26]), $sampled(opcode_o));
		end

	chk_xo: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> xo_o == head_word[10:1])
		else begin
			field_errors++;
			$display("[FAIL] xo: expected %0d, actual %0d",
				$sampled(head_word[10:1]), $sampled(xo_o));
		end

	chk_rc: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> rc_o == head_word[0])
		else begin
			field_errors++;
			$display("[FAIL] rc: expected %0d, actual %0d",
				$sampled(head_word[0]), $sampled(rc_o));
		end

	// BF for compares lands here
	chk_reg1: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> reg1_o == exp_res.r1)
		else begin
			field_errors++;
			$display("[FAIL] reg1: expected %0d, actual %0d",
				$sampled(exp_res.r1), $sampled(reg1_o));
		end

	chk_reg2: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> reg2_o == exp_res.r2)
		else begin
			field_errors++;
			$display("[FAIL] reg2: expected %0d, actual %0d",
				$sampled(exp_res.r2), $sampled(reg2_o));
		end

	chk_reg3: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> reg3_o == exp_res.r3)
		else begin
			field_errors++;
			$display("[FAIL] reg3: expected %0d, actual %0d",
				$sampled(exp_res.r3), $sampled(reg3_o));
		end

	chk_ra_zero: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> ra_zero_o == exp_res.raz)
		else begin
			field_errors++;
			$display("[FAIL] ra_zero: expected %0d, actual %0d",
				$sampled(exp_res.raz), $sampled(ra_zero_o));
		end

	chk_illegal: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && head_present |-> illegal_o == exp_res.illegal)
		else begin
			field_errors++;
			$display("[FAIL] illegal: expected %0d, actual %0d",
				$sampled(exp_res.illegal), $sampled(illegal_o));
		end

	//////////////////////////////////////////////////////////////////////
	// handshake
	//////////////////////////////////////////////////////////////////////
	no_orphan: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o |-> head_present)
		else begin
			protocol_errors++;
			$display("output valid with no accepted word waiting");
		end

	stall_hold: assert property (@(posedge clock_i) disable iff (reset_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable({opcode_o, xo_o,
		reg1_o, reg2_o, reg3_o, ra_zero_o, rc_o, illegal_o}))
		else begin
			protocol_errors++;
			$display("output changed or dropped while the sink was stalled");
		end

	// free or draining stage takes a new word every cycle
	ready_when_free: assert property (@(posedge clock_i) disable iff (reset_i)
		(!out_valid_o || out_ready_i) |-> in_ready_o)
		else begin
			protocol_errors++;
			$display("input not ready while the output stage was free or draining");
		end

	idle_after_reset: assert property (@(posedge clock_i)
		$fell(reset_i) |-> !out_valid_o && in_ready_o)
		else begin
			protocol_errors++;
			$display("stage not empty and ready after reset");
		end

	one_cycle_latency: assert property (@(posedge clock_i) disable iff (reset_i)
		in_valid_i && in_ready_o |=> out_valid_o)
		else begin
			protocol_errors++;
			$display("accepted word did not show on the output one cycle later");
		end

endmodule

//--- testbench/tb_xform_decoder.sv
`include "xform_defs.svh"

module tb_xform_decoder;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int STALL_BOUND = 16;

	logic clock_i;
	logic reset_i;
	logic in_valid_i;
	logic [31:0] in_insn_i;
	logic in_ready_o;
	logic out_valid_o;
	logic out_ready_i;
	logic [5:0] opcode_o;
	logic [9:0] xo_o;
	logic [4:0] reg1_o;
	logic [4:0] reg2_o;
	logic [4:0] reg3_o;
	logic ra_zero_o;
	logic rc_o;
	logic illegal_o;
	int field_errors;
	int protocol_errors;
	int accepted;
	int received;
	int pending;
	int tb_errors;

	logic [31:0] words[$];
	logic [9:0] fixed_codes[$] = '{`XF_XO_LBZX, `XF_XO_LHZX, `XF_XO_LHAX, `XF_XO_LWZX,
		`XF_XO_LWAX, `XF_XO_LDX, `XF_XO_STBX, `XF_XO_STHX, `XF_XO_STWX, `XF_XO_STDX,
		`XF_XO_LBZUX, `XF_XO_LHZUX, `XF_XO_LHAUX, `XF_XO_LWZUX, `XF_XO_LWAUX, `XF_XO_LDUX,
		`XF_XO_STBUX, `XF_XO_STHUX, `XF_XO_STWUX, `XF_XO_STDUX, `XF_XO_CMP, `XF_XO_CMPL,
		`XF_XO_AND, `XF_XO_OR, `XF_XO_XOR, `XF_XO_NAND, `XF_XO_NOR, `XF_XO_EQV,
		`XF_XO_ANDC, `XF_XO_ORC, `XF_XO_SLW, `XF_XO_SRW, `XF_XO_SRAW, `XF_XO_SLD,
		`XF_XO_SRD, `XF_XO_SRAD, `XF_XO_EXTSB, `XF_XO_EXTSH, `XF_XO_EXTSW, `XF_XO_CNTLZW,
		`XF_XO_CNTLZD, `XF_XO_POPCNTB, `XF_XO_PRTYW, 10'd1, 10'd266, 10'd999, 10'd700};
	logic [9:0] float_codes[$] = '{`XF_XO_FMR, `XF_XO_FNEG, `XF_XO_FABS, `XF_XO_FNABS,
		`XF_XO_FCPSGN, `XF_XO_FCMPU, `XF_XO_FCMPO, `XF_XO_FRSP, `XF_XO_FCTIW,
		`XF_XO_FCTIWZ, `XF_XO_FCTID, `XF_XO_FCTIDZ, 10'd1, 10'd583, 10'd711};
	// primaries that neither decoder owns
	logic [5:0] other_opcodes[$] = '{6'd0, 6'd14, 6'd32, 6'd62};

	xform_decoder_top UUT (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.in_valid_i (in_valid_i),
		.in_insn_i (in_insn_i),
		.in_ready_o (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.opcode_o (opcode_o),
		.xo_o (xo_o),
		.reg1_o (reg1_o),
		.reg2_o (reg2_o),
		.reg3_o (reg3_o),
		.ra_zero_o (ra_zero_o),
		.rc_o (rc_o),
		.illegal_o (illegal_o)
	);

	xform_decoder_checks checks (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.in_valid_i (in_valid_i),
		.in_insn_i (in_insn_i),
		.in_ready_o (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.opcode_o (opcode_o),
		.xo_o (xo_o),
		.reg1_o (reg1_o),
		.reg2_o (reg2_o),
		.reg3_o (reg3_o),
		.ra_zero_o (ra_zero_o),
		.rc_o (rc_o),
		.illegal_o (illegal_o),
		.field_errors_o (field_errors),
		.protocol_errors_o (protocol_errors),
		.accepted_o (accepted),
		.received_o (received),
		.pending_o (pending)
	);

	always #(CLK_PERIOD / 2) clock_i = ~clock_i;

	// random register fields and Rc around a fixed opcode and XO
	function automatic logic [31:0] build_word(input logic [5:0] opcd, input logic [9:0] xo);
		return {opcd, 5'($urandom), 5'($urandom), 5'($urandom), xo, 1'($urandom)};
	endfunction

	task automatic send_word(input logic [31:0] w);
		logic taken;
		taken = 1'b0;
		in_valid_i = 1'b1;
		in_insn_i = w;
		while (!taken) begin
			@(negedge clock_i);
			taken = in_ready_o;
			@(posedge clock_i);
			#2;
		end
		in_valid_i = 1'b0;
		repeat ($urandom % 3) begin
			@(posedge clock_i);
			#2;
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// sink stalls
	////////////////////////////////////////////////////////////////////
	initial begin
		out_ready_i = 1'b1;
		@(negedge reset_i);
		forever begin
			@(posedge clock_i);
			#2;
			out_ready_i = ($urandom % 4) != 0;
		end
	end

	initial begin
		void'($urandom(32'h834b));
		clock_i = 1'b0;
		reset_i = 1'b1;
		in_valid_i = 1'b0;
		in_insn_i = '0;
		tb_errors = 0;
		foreach (fixed_codes[i]) words.push_back(build_word(`XF_OPCD_FIXED, fixed_codes[i]));
		foreach (float_codes[i]) words.push_back(build_word(`XF_OPCD_FLOAT, float_codes[i]));
		foreach (other_opcodes[i]) words.push_back(build_word(other_opcodes[i], 10'($urandom)));
		repeat (10) @(posedge clock_i);
		#2;
		reset_i = 1'b0;
		foreach (words[i]) send_word(words[i]);
		while (pending != 0) @(posedge clock_i);
		repeat (3) @(posedge clock_i);
		if (accepted != words.size() || received != accepted) begin
			tb_errors++;
			$display("word count mismatch, sent %0d accepted %0d received %0d",
				words.size(), accepted, received);
		end
		$display("errors: %0d field, %0d protocol, %0d count",
			field_errors, protocol_errors, tb_errors);
		if (field_errors + protocol_errors + tb_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#1;
		#((words.size() * STALL_BOUND + 20) * CLK_PERIOD);
		$display("timeout, stimulus did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+src
src/xform_pkg.sv
src/fixed_point_xo_decoder.sv
src/float_xo_decoder.sv
src/xform_result_merge.sv
src/xform_decoder_top.sv
testbench/xform_decoder_checks.sv
testbench/tb_xform_decoder.sv

//--- Makefile
# Verilator build and run for the X-form decoder testbench

VERILATOR ?= verilator
TOP ?= tb_xform_decoder
OBJ_DIR ?= obj_dir
FILELIST ?= filelist.f
VFLAGS ?= --binary --assert
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv testbench/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
